// ==== src.f ====
+incdir+logic
logic/mvau_ctrl_pkg.sv
logic/mvau_data_pkg.sv
logic/mvau_control_block.sv
logic/mvau_input_buffer.sv
logic/mvau_pe_array.sv
logic/mvau_top.sv
sim/mvau_assert.sv
sim/mvau_checker.sv
sim/mvau_tb.sv

// ==== sim/mvau_testdata.txt ====
// Word 0 is the vector count, then the weights row by row (SF per line),
// then per vector one line of SF activations and one line of ROWS sums, hex
5
// Weights, rows 0 to 3, row 3 at full scale
1 2 3 4 5 6 7 8
8 7 6 5 4 3 2 1
0 f 0 f 3 c 5 a
f f f f f f f f
// Vector 0, all ones
1 1 1 1 1 1 1 1
24 24 3c 78
// Vector 1, sparse
2 0 3 0 4 0 5 0
42 3c 25 d2
// Vector 2, full scale activations
f f f f f f f f
21c 21c 384 708
// Vector 3, zeros right after full scale
0 0 0 0 0 0 0 0
0 0 0 0
// Vector 4, mixed
0 9 a b c d e f
1c0 134 2c8 4ec

// ==== sim/mvau_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mvau_params.svh"

// Testbench of the MVAU
// Weights are written under reset, activations follow act_req
module mvau_tb;

   localparam int          CLK_PERIOD  = 40;
   localparam int          RST_CYCLES  = 16;
   localparam logic [31:0] SEED        = 32'hcacef393;
   localparam int          MAX_VEC     = 8;
   localparam int          VEC_WORDS   = `MVAU_SF + `MVAU_ROWS; // Activations, then sums
   localparam int          LOAD_CYCLES = `MVAU_ROWS * `MVAU_SF;
   localparam int          WGT_BASE    = 1;                     // Word 0 is the vector count
   localparam int          VEC_BASE    = WGT_BASE + LOAD_CYCLES;
   localparam int          TD_DEPTH    = VEC_BASE + MAX_VEC * VEC_WORDS;
   localparam int          RST_SPAN    = (LOAD_CYCLES > RST_CYCLES ? LOAD_CYCLES : RST_CYCLES) + 1;

   logic                                    clk;
   logic                                    rst_n;
   logic                                    wgt_wen;
   logic [`MVAU_ROW_T-1:0]                  wgt_row;
   logic [`MVAU_SF_T-1:0]                   wgt_col;
   logic [`MVAU_TW-1:0]                     wgt_data;
   logic [`MVAU_AW-1:0]                     act_in;
   logic                                    act_req;
   logic                                    out_valid;
   logic [`MVAU_ROW_T-1:0]                  out_row;
   logic [`MVAU_PE*`MVAU_ACCW-1:0]          out_acc;
   logic [`MVAU_ACCW-1:0]                   tdata [TD_DEPTH]; // Data file image
   logic [`MVAU_ROWS*`MVAU_SF*`MVAU_TW-1:0] wgt_flat;
   logic                                    vec_push;
   logic [`MVAU_SF*`MVAU_AW-1:0]            vec_acts;
   logic [`MVAU_ROWS*`MVAU_ACCW-1:0]        vec_exp;
   logic [7:0]                              n_vec;
   logic                                    chk_done;
   int                                      chk_err;

   mvau_top i_mvau_top (
      .clk       (clk),
      .rst_n     (rst_n),
      .wgt_wen   (wgt_wen),
      .wgt_row   (wgt_row),
      .wgt_col   (wgt_col),
      .wgt_data  (wgt_data),
      .act_in    (act_in),
      .act_req   (act_req),
      .out_valid (out_valid),
      .out_row   (out_row),
      .out_acc   (out_acc)
   );

   mvau_checker i_checker (
      .clk       (clk),
      .rst_n     (rst_n),
      .act_req   (act_req),
      .out_valid (out_valid),
      .out_row   (out_row),
      .out_acc   (out_acc),
      .wgt_flat  (wgt_flat),
      .vec_push  (vec_push),
      .vec_acts  (vec_acts),
      .vec_exp   (vec_exp),
      .n_vec     (n_vec),
      .done      (chk_done),
      .err_cnt   (chk_err)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Whole weight matrix, one word per falling edge
   task automatic load_weights();
      @(negedge clk);
      for (int r = 0; r < `MVAU_ROWS; r++) begin
         for (int c = 0; c < `MVAU_SF; c++) begin
            wgt_wen  <= 1'b1;
            wgt_row  <= `MVAU_ROW_T'(r);
            wgt_col  <= `MVAU_SF_T'(c);
            wgt_data <= tdata[WGT_BASE + r*`MVAU_SF + c][`MVAU_TW-1:0];
            @(negedge clk);
         end
      end
      wgt_wen <= 1'b0;
   endtask

   task automatic hand_over_vector(input int base);
      for (int c = 0; c < `MVAU_SF; c++) begin
         vec_acts[c*`MVAU_AW +: `MVAU_AW] <= tdata[base + c][`MVAU_AW-1:0];
      end
      for (int r = 0; r < `MVAU_ROWS; r++) begin
         vec_exp[r*`MVAU_ACCW +: `MVAU_ACCW] <= tdata[base + `MVAU_SF + r];
      end
      vec_push <= 1'b1;
   endtask

   // One step per falling edge until the run ends
   task automatic feed_activations();
      int v;
      int col;
      int base;
      v   = 0;
      col = 0;
      forever begin
         vec_push <= 1'b0;
         wgt_row  <= `MVAU_ROW_T'($urandom); // Strobe stays low
         wgt_col  <= `MVAU_SF_T'($urandom);
         wgt_data <= `MVAU_TW'($urandom);
         if (act_req && v < n_vec) begin
            base = VEC_BASE + v * VEC_WORDS;
            if (col == 0) begin
               hand_over_vector(base);
            end
            act_in <= tdata[base + col][`MVAU_AW-1:0];
            col++;
            if (col == `MVAU_SF) begin
               col = 0;
               v++;
            end
         end else begin
            act_in <= `MVAU_AW'($urandom);    // Idle or past the file, unchecked
         end
         @(negedge clk);
      end
   endtask

   initial begin
      rst_n    = 1'b0;
      wgt_wen  = 1'b0;
      wgt_row  = '0;
      wgt_col  = '0;
      wgt_data = '0;
      act_in   = '0;
      vec_push = 1'b0;
      vec_acts = '0;
      vec_exp  = '0;
      wgt_flat = '0;
      n_vec    = '0;
      void'($urandom(SEED));
      $readmemh("sim/mvau_testdata.txt", tdata);
      if ($isunknown(tdata[0]) || tdata[0] == 0 || tdata[0] > MAX_VEC) begin
         $display("data file sim/mvau_testdata.txt is missing or has no usable vector count");
         $display("test failed");
         $finish;
      end else begin
         n_vec = tdata[0][7:0];
         for (int i = 0; i < LOAD_CYCLES; i++) begin
            wgt_flat[i*`MVAU_TW +: `MVAU_TW] = tdata[WGT_BASE + i][`MVAU_TW-1:0];
         end
         fork  // Reset lasts until the matrix is in
            load_weights();
            repeat (RST_CYCLES) @(negedge clk);
         join
         rst_n <= 1'b1;
         fork
            feed_activations();
         join_none
         wait (chk_done);
         if (chk_err == 0 && i_mvau_top.i_mvau_assert.n_fail == 0) begin
            $display("test passed");
         end else begin
            $display("test failed");
         end
         $finish;
      end
   end

   // Watchdog, twice the expected run plus two spare vectors
   initial begin
      longint limit;
      wait (n_vec != 0);
      limit = (longint'(RST_SPAN) + (longint'(n_vec) + 2) * `MVAU_NF * `MVAU_SF * 2) * CLK_PERIOD;
      #(limit);
      $display("timeout: not all results arrived within %0d ns", limit);
      $display("test failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sim/mvau_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mvau_params.svh"

// Scoreboard of the MVAU
// Works out row sums from the weights and each vector, then compares
// every result pulse in order, plus the act_req and out_valid timing
module mvau_checker (
   input  wire logic                                    clk,
   input  wire logic                                    rst_n,
   input  wire logic                                    act_req,
   input  wire logic                                    out_valid,
   input  wire logic [`MVAU_ROW_T-1:0]                  out_row,
   input  wire logic [`MVAU_PE*`MVAU_ACCW-1:0]          out_acc,
   input  wire logic [`MVAU_ROWS*`MVAU_SF*`MVAU_TW-1:0] wgt_flat,  // Row by column
   input  wire logic                                    vec_push,  // New vector handed over
   input  wire logic [`MVAU_SF*`MVAU_AW-1:0]            vec_acts,
   input  wire logic [`MVAU_ROWS*`MVAU_ACCW-1:0]        vec_exp,   // Sums listed in the file
   input  wire logic [7:0]                              n_vec,
   output logic                                         done,
   output int                                           err_cnt
);

   localparam int PERIOD = `MVAU_NF * `MVAU_SF; // Cycles per vector

   logic [`MVAU_ACCW-1:0] ref_q [$]; // Row sums, vector after vector
   int n_res;                        // Result pulses compared
   int vec_err;                      // Errors within the current vector
   int k;                            // Cycles since reset release

   initial begin
      done    = 1'b0;
      err_cnt = 0;
      n_res   = 0;
      vec_err = 0;
      k       = 0;
   end

   // Sum over all columns of weight times activation
   function automatic int row_sum(input int row, input logic [`MVAU_SF*`MVAU_AW-1:0] acts);
      int s;
      s = 0;
      for (int c = 0; c < `MVAU_SF; c++) begin
         s += wgt_flat[(row*`MVAU_SF + c)*`MVAU_TW +: `MVAU_TW] * acts[c*`MVAU_AW +: `MVAU_AW];
      end
      return s;
   endfunction

   task automatic take_vector();
      int s;
      for (int r = 0; r < `MVAU_ROWS; r++) begin
         s = row_sum(r, vec_acts);
         if (s != vec_exp[r*`MVAU_ACCW +: `MVAU_ACCW]) begin  // Data file is wrong
            $display("file error: vector row %0d lists %0d but weights and activations give %0d",
                     r, vec_exp[r*`MVAU_ACCW +: `MVAU_ACCW], s);
            err_cnt++;
         end
         ref_q.push_back(`MVAU_ACCW'(s));
      end
   endtask

   task automatic check_timing();
      logic exp_req;
      logic exp_valid;
      exp_req   = (k % PERIOD) < `MVAU_SF;                           // Fold 0 takes inputs
      exp_valid = (k > `MVAU_SF) && ((k - 1) % `MVAU_SF == 0);       // Two after column SF-1
      if (act_req !== exp_req) begin
         $display("MISMATCH at %0t: act_req got %b expected %b", $time, act_req, exp_req);
         err_cnt++;
         vec_err++;
      end
      if (out_valid !== exp_valid) begin
         $display("MISMATCH at %0t: out_valid got %b expected %b", $time, out_valid, exp_valid);
         err_cnt++;
         vec_err++;
      end
   endtask

   task automatic check_result();
      int fold;
      int vec;
      int idx;
      logic [`MVAU_ACCW-1:0] got;
      fold = n_res % `MVAU_NF;
      vec  = n_res / `MVAU_NF;
      if (out_row !== `MVAU_ROW_T'(fold * `MVAU_PE)) begin
         $display("MISMATCH at %0t: out_row got %0d expected %0d", $time, out_row,
                  fold * `MVAU_PE);
         err_cnt++;
         vec_err++;
      end
      for (int p = 0; p < `MVAU_PE; p++) begin
         idx = vec * `MVAU_ROWS + fold * `MVAU_PE + p;
         got = out_acc[p*`MVAU_ACCW +: `MVAU_ACCW];
         if (idx >= ref_q.size()) begin
            $display("result for vector %0d came before that vector was fed", vec);
            err_cnt++;
            vec_err++;
         end else if (got !== ref_q[idx]) begin
            $display("MISMATCH at %0t: out_acc[%0d] got %0d expected %0d", $time, p, got,
                     ref_q[idx]);
            err_cnt++;
            vec_err++;
         end
      end
      n_res++;
      if (fold == `MVAU_NF - 1) begin  // Vector complete
         if (vec_err == 0) begin
            $display("vector %0d: all %0d rows ok", vec, `MVAU_ROWS);
         end else begin
            $display("vector %0d: %0d errors", vec, vec_err);
         end
         vec_err = 0;
      end
      if (n_res == n_vec * `MVAU_NF) begin
         $display("summary: %0d vectors, %0d results, %0d errors", n_vec, n_res, err_cnt);
         done = 1'b1;
      end
   endtask

   always @(posedge clk) begin
      if (vec_push) begin
         take_vector();
      end
   end

   // Outputs are settled at the falling edge
   always @(negedge clk) begin
      if (!rst_n) begin
         k = 0;
      end else if (!done) begin
         k++;
         check_timing();
         if (out_valid === 1'b1 && n_res < n_vec * `MVAU_NF) begin
            check_result();
         end
      end
   end

endmodule

`default_nettype wire

// ==== sim/mvau_assert.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mvau_params.svh"

// Internal protocol checks of the MVAU, bound into every mvau_top
module mvau_assert
   import mvau_ctrl_pkg::*;
(
   input wire logic    clk,
   input wire logic    rst_n,
   input wire logic    ib_wen,
   input wire logic    out_valid,
   input wire sf_cnt_t sf_cnt
);

   int n_fail; // Failed assertions so far, read by the testbench

   initial n_fail = 0;

   // Buffer phase only switches where a new column pass begins
   a_phase_at_wrap : assert property (
      @(posedge clk) disable iff (!rst_n) $changed(ib_wen) |-> sf_cnt == '0
   ) else begin
      n_fail++;
      $error("ib_wen changed away from a column wrap");
   end

   // One pulse per fold
   a_valid_single : assert property (
      @(posedge clk) disable iff (!rst_n) out_valid |=> !out_valid
   ) else begin
      n_fail++;
      $error("out_valid high in two consecutive cycles");
   end

   // Result pulse trails the last column by two cycles
   a_valid_after_wrap : assert property (
      @(posedge clk) disable iff (!rst_n)
         out_valid |-> $past(sf_cnt, 2) == sf_cnt_t'(`MVAU_SF - 1)
   ) else begin
      n_fail++;
      $error("out_valid not two cycles after the last column");
   end

endmodule

bind mvau_top mvau_assert i_mvau_assert (
   .clk       (clk),
   .rst_n     (rst_n),
   .ib_wen    (ib_wen),
   .out_valid (out_valid),
   .sf_cnt    (sf_cnt)
);

`default_nettype wire

// ==== logic/mvau_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mvau_params.svh"

// Matrix-vector activation unit
// Control block feeds tile and buffer addresses, the buffer feeds
// activations, the PE array turns both into row sums
module mvau_top
   import mvau_ctrl_pkg::*;
   import mvau_data_pkg::*;
(
   input  wire logic                   clk,
   input  wire logic                   rst_n,
   input  wire logic                   wgt_wen,
   input  wire logic [`MVAU_ROW_T-1:0] wgt_row,
   input  wire sf_cnt_t                wgt_col,
   input  wire wgt_t                   wgt_data,
   input  wire act_t                   act_in,
   output logic                        act_req,   // act_in consumed this cycle
   output logic                        out_valid,
   output logic [`MVAU_ROW_T-1:0]      out_row,
   output acc_t [`MVAU_PE-1:0]         out_acc
);

   logic                ib_wen;
   logic                ib_ren;
   sf_cnt_t             sf_cnt;
   nf_cnt_t             nf_cnt;   // Stage 1 fold tag
   logic                last_col;
   wgt_t [`MVAU_PE-1:0] wgt_tile;
   act_t                act_q;

   // Activations are only taken while the buffer fills
   assign act_req = ib_wen;

   mvau_control_block i_control_block (
      .clk      (clk),
      .rst_n    (rst_n),
      .wgt_wen  (wgt_wen),
      .wgt_row  (wgt_row),
      .wgt_col  (wgt_col),
      .wgt_data (wgt_data),
      .ib_wen   (ib_wen),
      .ib_ren   (ib_ren),
      .sf_cnt   (sf_cnt),
      .nf_cnt   (nf_cnt),
      .last_col (last_col),
      .wgt_tile (wgt_tile)
   );

   mvau_input_buffer i_input_buffer (
      .clk    (clk),
      .rst_n  (rst_n),
      .ib_wen (ib_wen),
      .ib_ren (ib_ren),
      .sf_cnt (sf_cnt),
      .act_in (act_in),
      .act_q  (act_q)
   );

   mvau_pe_array i_pe_array (
      .clk       (clk),
      .rst_n     (rst_n),
      .act_q     (act_q),
      .wgt_tile  (wgt_tile),
      .last_col  (last_col),
      .nf_cnt    (nf_cnt),
      .out_valid (out_valid),
      .out_row   (out_row),
      .out_acc   (out_acc)
   );

endmodule

`default_nettype wire

// ==== logic/mvau_pe_array.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mvau_params.svh"

// PE array, stage 2 of the MVAU
// One multiply-accumulate lane per row of the current fold
module mvau_pe_array
   import mvau_data_pkg::*;
(
   input  wire logic                   clk,
   input  wire logic                   rst_n,
   input  wire act_t                   act_q,     // Shared by all lanes
   input  wire wgt_t [`MVAU_PE-1:0]    wgt_tile,  // One weight per lane
   input  wire logic                   last_col,  // Stage 1 holds column SF-1
   input  wire logic [`MVAU_NF_T-1:0]  nf_cnt,    // Fold tag of stage 1
   output logic                        out_valid, // One cycle per fold
   output logic [`MVAU_ROW_T-1:0]      out_row,   // First row of the tile
   output acc_t [`MVAU_PE-1:0]         out_acc    // Lane accumulators
);

   prod_t prod [`MVAU_PE]; // Lane products
   logic  s1_live;         // Stage 1 registers hold real data

   // Unsigned products, full width
   always_comb begin
      for (int p = 0; p < `MVAU_PE; p++) begin
         prod[p] = act_q * wgt_tile[p];
      end
   end

   // Stage 1 is loaded from the first edge after reset onwards,
   // so the lanes skip that one edge
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         s1_live <= 1'b0;
      end else begin
         s1_live <= 1'b1;
      end
   end

   // Result strobe, lands together with the last column's sum
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= last_col;
      end
   end

   // Row tag of the fold being closed
   always_ff @(posedge clk) begin
      if (last_col) begin
         out_row <= `MVAU_ROW_T'(nf_cnt * `MVAU_PE);
      end
   end

   // Accumulators double as the result outputs
   // The column after a finished fold loads its product fresh,
   // which drops the old sum right after the pulse
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_acc <= '0;
      end else if (s1_live) begin
         for (int p = 0; p < `MVAU_PE; p++) begin
            if (out_valid) begin
               out_acc[p] <= acc_t'(prod[p]);              // Restart
            end else begin
               out_acc[p] <= out_acc[p] + acc_t'(prod[p]); // Accumulate
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== logic/mvau_input_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mvau_params.svh"

// Activation buffer
// Captures one vector during fold 0 and plays it back for every
// later fold, so each activation is fetched from outside only once
module mvau_input_buffer
   import mvau_ctrl_pkg::*;
   import mvau_data_pkg::*;
(
   input  wire logic    clk,
   input  wire logic    rst_n,
   input  wire logic    ib_wen,  // Fill phase
   input  wire logic    ib_ren,  // Reuse phase
   input  wire sf_cnt_t sf_cnt,  // Column address
   input  wire act_t    act_in,  // Activation from outside
   output act_t         act_q    // Stage 1 activation to the PE array
);

   act_t   mem [`MVAU_SF]; // One word per column
   phase_e phase;

   assign phase = ib_wen ? ph_fill : ph_reuse;

   // Store the incoming vector while filling
   always_ff @(posedge clk) begin
      if (phase == ph_fill) begin
         mem[sf_cnt] <= act_in;
      end
   end

   // Stage 1 register
   // Fill bypasses the memory so fold 0 sees the word right away
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         act_q <= '0;
      end else begin
         case (phase)
            ph_fill: begin
               act_q <= act_in;       // Bypass
            end
            ph_reuse: begin
               if (ib_ren) begin
                  act_q <= mem[sf_cnt]; // Replay stored column
               end
            end
            default: begin
               act_q <= '0;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== logic/mvau_control_block.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mvau_params.svh"

// Sequencer of the MVAU
// Runs the column and fold counters, owns the weight matrix and
// hands one weight tile per cycle to the PE array
module mvau_control_block
   import mvau_ctrl_pkg::*;
   import mvau_data_pkg::*;
(
   input  wire logic                  clk,
   input  wire logic                  rst_n,
   // Weight load port
   input  wire logic                  wgt_wen,   // Write strobe
   input  wire logic [`MVAU_ROW_T-1:0] wgt_row,
   input  wire sf_cnt_t               wgt_col,
   input  wire wgt_t                  wgt_data,
   // Input buffer control
   output logic                       ib_wen,    // High during fold 0
   output logic                       ib_ren,    // High during later folds
   output sf_cnt_t                    sf_cnt,    // Live column, buffer address
   // Stage 1 towards the PE array
   output nf_cnt_t                    nf_cnt,    // Fold tag of the current tile
   output logic                       last_col,  // Tile belongs to column SF-1
   output wgt_t [`MVAU_PE-1:0]        wgt_tile   // One weight per lane
);

   wgt_t    wmem [`MVAU_ROWS][`MVAU_SF]; // Weight matrix, row by column
   nf_cnt_t nf_q;                        // Live fold counter
   phase_e  phase;
   logic    sf_last;                     // Column SF-1 this cycle
   logic    nf_last;                     // Last fold this cycle

   // Weight memory, written whenever the strobe is up
   // Loading is allowed while the rest of the block sits in reset
   always_ff @(posedge clk) begin
      if (wgt_wen) begin
         wmem[wgt_row][wgt_col] <= wgt_data;
      end
   end

   assign sf_last = (sf_cnt == sf_cnt_t'(`MVAU_SF - 1));
   assign nf_last = (nf_q == nf_cnt_t'(`MVAU_NF - 1));

   // Column counter, wraps after SF-1
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         sf_cnt <= '0;
      end else if (sf_last) begin
         sf_cnt <= '0;
      end else begin
         sf_cnt <= sf_cnt + 1'b1;
      end
   end

   // Fold counter, steps once per full pass over the columns
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         nf_q <= '0;
      end else if (sf_last) begin
         if (nf_last) begin
            nf_q <= '0;    // Next vector starts
         end else begin
            nf_q <= nf_q + 1'b1;
         end
      end
   end

   // Phase follows the fold, fold 0 fills the buffer
   assign phase  = (nf_q == '0) ? ph_fill : ph_reuse;
   assign ib_wen = (phase == ph_fill);
   assign ib_ren = (phase == ph_reuse);  // Exact complement of ib_wen

   // Tile pick, rows nf*PE+p at the live column
   // Registered so it lines up with act_q out of the buffer
   always_ff @(posedge clk) begin
      for (int p = 0; p < `MVAU_PE; p++) begin
         wgt_tile[p] <= wmem[int'(nf_q) * `MVAU_PE + p][sf_cnt];
      end
   end

   // Column and fold tags travel with the tile
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         last_col <= 1'b0;
         nf_cnt   <= '0;
      end else begin
         last_col <= sf_last;
         nf_cnt   <= nf_q;
      end
   end

endmodule

`default_nettype wire

// ==== logic/mvau_data_pkg.sv ====
`default_nettype none

`include "mvau_params.svh"

// Types of the arithmetic side
package mvau_data_pkg;

   // One activation element
   typedef logic [`MVAU_AW-1:0] act_t;

   // One weight element
   typedef logic [`MVAU_TW-1:0] wgt_t;

   // Full product, no rounding
   typedef logic [`MVAU_AW+`MVAU_TW-1:0] prod_t;

   // Row accumulator
   typedef logic [`MVAU_ACCW-1:0] acc_t;

endpackage

`default_nettype wire

// ==== logic/mvau_ctrl_pkg.sv ====
`default_nettype none

`include "mvau_params.svh"

// Types of the sequencing side: phase and counters
package mvau_ctrl_pkg;

   // Buffer phase, follows the fold counter
   typedef enum logic {
      ph_fill  = 1'b0, // Fold 0, vector is written into the buffer
      ph_reuse = 1'b1  // Later folds, vector is replayed
   } phase_e;

   // Column counter, doubles as buffer address
   typedef logic [`MVAU_SF_T-1:0] sf_cnt_t;

   // Fold counter
   typedef logic [`MVAU_NF_T-1:0] nf_cnt_t;

endpackage

`default_nettype wire

// ==== logic/mvau_params.svh ====
`ifndef MVAU_PARAMS_SVH
`define MVAU_PARAMS_SVH

// Matrix shape
`define MVAU_PE    2                      // Processing elements, rows per fold
`define MVAU_NF    2                      // Neuron folds
`define MVAU_SF    8                      // Columns, length of one activation vector
`define MVAU_ROWS  (`MVAU_PE * `MVAU_NF)  // Weight matrix height

// Element widths, all unsigned
`define MVAU_TW    4                      // Weight
`define MVAU_AW    4                      // Activation
`define MVAU_ACCW  12                     // Holds SF products of AW+TW bits

// Counter and index widths, never below one bit
`define MVAU_SF_T  (($clog2(`MVAU_SF) > 0) ? $clog2(`MVAU_SF) : 1)
`define MVAU_NF_T  (($clog2(`MVAU_NF) > 0) ? $clog2(`MVAU_NF) : 1)
`define MVAU_ROW_T (($clog2(`MVAU_ROWS) > 0) ? $clog2(`MVAU_ROWS) : 1)

`endif
